/* rtl/burst_split_pkg.sv */
package burst_split_pkg;

  // ------------------------------
  // Bus field widths
  // ------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  id_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  burst_t;
  typedef logic [1:0]  resp_t;

  // ------------------------------
  // AXI encodings
  // ------------------------------
  localparam burst_t BURST_FIXED = 2'd0;
  localparam burst_t BURST_INCR  = 2'd1;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // Outstanding bursts per direction
  localparam int unsigned MAX_TXNS = 4;
  localparam int unsigned QIDX_W   = $clog2(MAX_TXNS);

  // ------------------------------
  // State machines
  // ------------------------------
  typedef enum logic {IDLE, BUSY} ax_state_e;
  typedef enum logic {FWD, HOLD} rsp_state_e;

endpackage

/* rtl/len_queue_if.sv */
`timescale 1ns/1ps

interface len_queue_if import burst_split_pkg::*; ();

  // Allocation side, written once per accepted burst
  logic alloc_valid;
  len_t alloc_len;
  logic alloc_ready;

  // Count side, one decrement per response beat
  logic cnt_valid;
  logic cnt_last;
  logic cnt_dec;

  modport splitter (
    output alloc_valid,
    output alloc_len,
    input  alloc_ready
  );

  modport queue (
    input  alloc_valid,
    input  alloc_len,
    output alloc_ready,
    output cnt_valid,
    output cnt_last,
    input  cnt_dec
  );

  modport consumer (
    input  cnt_valid,
    input  cnt_last,
    output cnt_dec
  );

endinterface

/* rtl/ax_splitter.sv */
`timescale 1ns/1ps

module ax_splitter import burst_split_pkg::*; (
  input  logic   clk_i,
  input  logic   reset_i,
  // Upstream address channel
  input  id_t    id_i,
  input  addr_t  addr_i,
  input  len_t   len_i,
  input  size_t  size_i,
  input  burst_t burst_i,
  input  logic   valid_i,
  output logic   ready_o,
  // Downstream single-beat requests
  output id_t    id_o,
  output addr_t  addr_o,
  output size_t  size_o,
  output burst_t burst_o,
  output logic   valid_o,
  input  logic   ready_i,
  len_queue_if.splitter q
);

  ax_state_e state_q, state_d;
  id_t       id_q, id_d;
  addr_t     addr_q, addr_d;
  size_t     size_q, size_d;
  burst_t    burst_q, burst_d;
  // Beats still to send after the current one
  len_t      len_q, len_d;

  assign q.alloc_len = len_i;

  always_comb begin
    state_d       = state_q;
    id_d          = id_q;
    addr_d        = addr_q;
    size_d        = size_q;
    burst_d       = burst_q;
    len_d         = len_q;
    id_o          = id_i;
    addr_o        = addr_i;
    size_o        = size_i;
    burst_o       = burst_i;
    valid_o       = 1'b0;
    ready_o       = 1'b0;
    q.alloc_valid = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (valid_i && q.alloc_ready) begin
          valid_o = 1'b1;
          if (len_i == '0) begin
            // Single beat, nothing to split
            if (ready_i) begin
              ready_o       = 1'b1;
              q.alloc_valid = 1'b1;
            end
          end else begin
            // Take the burst now and offer its first beat right away
            ready_o       = 1'b1;
            q.alloc_valid = 1'b1;
            id_d          = id_i;
            size_d        = size_i;
            burst_d       = burst_i;
            addr_d        = addr_i;
            len_d         = len_i;
            if (ready_i) begin
              len_d = len_i - 1'b1;
              if (burst_i == BURST_INCR) begin
                addr_d = addr_i + (addr_t'(1) << size_i);
              end
            end
            state_d = BUSY;
          end
        end
      end
      BUSY: begin
        id_o    = id_q;
        addr_o  = addr_q;
        size_o  = size_q;
        burst_o = burst_q;
        valid_o = 1'b1;
        if (ready_i) begin
          if (len_q == '0) begin
            state_d = IDLE;
          end else begin
            len_d = len_q - 1'b1;
            // FIXED bursts keep the address
            if (burst_q == BURST_INCR) begin
              addr_d = addr_q + (addr_t'(1) << size_q);
            end
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q    <= id_d;
    addr_q  <= addr_d;
    size_q  <= size_d;
    burst_q <= burst_d;
    len_q   <= len_d;
  end

  // Upstream master sends only INCR or FIXED bursts
  assume property (@(posedge clk_i) disable iff (reset_i)
    valid_i && (len_i != '0) |-> (burst_i == BURST_INCR) || (burst_i == BURST_FIXED));

  // A refused first beat of an accepted burst is offered again from the register
  assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i && ready_o && (len_i != '0) && !ready_i |=>
      valid_o && (addr_o == $past(addr_i)) && (id_o == $past(id_i)))
    else $error("refused first beat of a burst was not offered again");

endmodule

/* rtl/burst_len_queue.sv */
`timescale 1ns/1ps

module burst_len_queue import burst_split_pkg::*; #(
  parameter int unsigned DEPTH = MAX_TXNS
) (
  input  logic clk_i,
  input  logic reset_i,
  len_queue_if.queue q
);

  len_t              mem [DEPTH];
  logic [QIDX_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [QIDX_W:0]   used_q;
  // Head counter takes over once the head entry sees its first beat
  logic              head_busy_q;
  len_t              head_cnt_q;
  len_t              head_cnt;
  logic              push, pop;

  function automatic logic [QIDX_W-1:0] next_ptr(input logic [QIDX_W-1:0] ptr);
    logic [QIDX_W-1:0] last_idx;
    last_idx = QIDX_W'(DEPTH - 1);
    return (ptr == last_idx) ? '0 : ptr + 1'b1;
  endfunction

  assign head_cnt      = head_busy_q ? head_cnt_q : mem[rd_ptr_q];
  assign q.cnt_valid   = (used_q != '0);
  assign q.cnt_last    = (head_cnt == '0);
  assign q.alloc_ready = (used_q != (QIDX_W + 1)'(DEPTH));

  assign push = q.alloc_valid && q.alloc_ready;
  assign pop  = q.cnt_dec && q.cnt_last;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      used_q      <= '0;
      head_busy_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        used_q <= used_q + 1'b1;
      end else if (pop && !push) begin
        used_q <= used_q - 1'b1;
      end
      if (q.cnt_dec) begin
        head_busy_q <= !q.cnt_last;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= q.alloc_len;
    end
    if (q.cnt_dec) begin
      head_cnt_q <= head_cnt - 1'b1;
    end
  end

  // Consumers only count beats of a burst that is known
  assert property (@(posedge clk_i) disable iff (reset_i)
    q.cnt_dec |-> q.cnt_valid)
    else $error("beat counted with empty length queue");

endmodule

/* rtl/b_merger.sv */
`timescale 1ns/1ps

module b_merger import burst_split_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  // Downstream B
  input  id_t   b_id_i,
  input  resp_t b_resp_i,
  input  logic  b_valid_i,
  output logic  b_ready_o,
  // Upstream B
  output id_t   b_id_o,
  output resp_t b_resp_o,
  output logic  b_valid_o,
  input  logic  b_ready_i,
  len_queue_if.consumer q
);

  rsp_state_e state_q, state_d;
  // Sticky error of the burst in flight, bit 1 marks SLVERR and DECERR
  logic       err_q, err_d;
  logic       merged_err;

  assign b_id_o     = b_id_i;
  assign merged_err = err_q || b_resp_i[1];
  assign b_resp_o   = merged_err ? RESP_SLVERR : b_resp_i;

  always_comb begin
    state_d   = state_q;
    err_d     = err_q;
    b_valid_o = 1'b0;
    b_ready_o = 1'b0;
    q.cnt_dec = 1'b0;
    unique case (state_q)
      FWD: begin
        if (b_valid_i && q.cnt_valid) begin
          q.cnt_dec = 1'b1;
          if (!q.cnt_last) begin
            // Swallow this beat and remember its error
            b_ready_o = 1'b1;
            err_d     = merged_err;
          end else begin
            b_valid_o = 1'b1;
            if (b_ready_i) begin
              b_ready_o = 1'b1;
              err_d     = 1'b0;
            end else begin
              state_d = HOLD;
              err_d   = merged_err;
            end
          end
        end
      end
      HOLD: begin
        b_valid_o = b_valid_i;
        if (b_valid_i && b_ready_i) begin
          b_ready_o = 1'b1;
          err_d     = 1'b0;
          state_d   = FWD;
        end
      end
      default: state_d = FWD;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= FWD;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
    end
  end

  // Every downstream B belongs to a write burst still in the queue
  assert property (@(posedge clk_i) disable iff (reset_i)
    b_valid_i |-> q.cnt_valid || (state_q == HOLD))
    else $error("B response without an outstanding write burst");

endmodule

/* rtl/r_last_gen.sv */
`timescale 1ns/1ps

module r_last_gen import burst_split_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  // Downstream R
  input  id_t   r_id_i,
  input  data_t r_data_i,
  input  resp_t r_resp_i,
  input  logic  r_valid_i,
  output logic  r_ready_o,
  // Upstream R
  output id_t   r_id_o,
  output data_t r_data_o,
  output resp_t r_resp_o,
  output logic  r_last_o,
  output logic  r_valid_o,
  input  logic  r_ready_i,
  len_queue_if.consumer q
);

  rsp_state_e state_q, state_d;
  logic       last_q, last_d;

  assign r_id_o   = r_id_i;
  assign r_data_o = r_data_i;
  assign r_resp_o = r_resp_i;

  always_comb begin
    state_d   = state_q;
    last_d    = last_q;
    r_last_o  = 1'b0;
    r_valid_o = 1'b0;
    r_ready_o = 1'b0;
    q.cnt_dec = 1'b0;
    unique case (state_q)
      FWD: begin
        if (r_valid_i && q.cnt_valid) begin
          // Beat is counted now, even if upstream stalls
          q.cnt_dec = 1'b1;
          r_valid_o = 1'b1;
          r_last_o  = q.cnt_last;
          last_d    = q.cnt_last;
          if (r_ready_i) begin
            r_ready_o = 1'b1;
          end else begin
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        r_valid_o = r_valid_i;
        r_last_o  = last_q;
        if (r_valid_i && r_ready_i) begin
          r_ready_o = 1'b1;
          state_d   = FWD;
        end
      end
      default: state_d = FWD;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= FWD;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    last_q <= last_d;
  end

  // Every downstream R belongs to a read burst still in the queue
  assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_i |-> q.cnt_valid || (state_q == HOLD))
    else $error("R beat without an outstanding read burst");

endmodule

/* rtl/burst_splitter.sv */
`timescale 1ns/1ps

module burst_splitter import burst_split_pkg::*; (
  input  logic   clk_i,
  input  logic   reset_i,
  // ------------------------------
  // Upstream (slave side)
  // ------------------------------
  input  id_t    aw_id_s_i,
  input  addr_t  aw_addr_s_i,
  input  len_t   aw_len_s_i,
  input  size_t  aw_size_s_i,
  input  burst_t aw_burst_s_i,
  input  logic   aw_valid_s_i,
  output logic   aw_ready_s_o,
  input  data_t  w_data_s_i,
  input  strb_t  w_strb_s_i,
  input  logic   w_valid_s_i,
  output logic   w_ready_s_o,
  output id_t    b_id_s_o,
  output resp_t  b_resp_s_o,
  output logic   b_valid_s_o,
  input  logic   b_ready_s_i,
  input  id_t    ar_id_s_i,
  input  addr_t  ar_addr_s_i,
  input  len_t   ar_len_s_i,
  input  size_t  ar_size_s_i,
  input  burst_t ar_burst_s_i,
  input  logic   ar_valid_s_i,
  output logic   ar_ready_s_o,
  output id_t    r_id_s_o,
  output data_t  r_data_s_o,
  output resp_t  r_resp_s_o,
  output logic   r_last_s_o,
  output logic   r_valid_s_o,
  input  logic   r_ready_s_i,
  // ------------------------------
  // Downstream (master side)
  // ------------------------------
  output id_t    aw_id_m_o,
  output addr_t  aw_addr_m_o,
  output len_t   aw_len_m_o,
  output size_t  aw_size_m_o,
  output burst_t aw_burst_m_o,
  output logic   aw_valid_m_o,
  input  logic   aw_ready_m_i,
  output data_t  w_data_m_o,
  output strb_t  w_strb_m_o,
  output logic   w_last_m_o,
  output logic   w_valid_m_o,
  input  logic   w_ready_m_i,
  input  id_t    b_id_m_i,
  input  resp_t  b_resp_m_i,
  input  logic   b_valid_m_i,
  output logic   b_ready_m_o,
  output id_t    ar_id_m_o,
  output addr_t  ar_addr_m_o,
  output len_t   ar_len_m_o,
  output size_t  ar_size_m_o,
  output burst_t ar_burst_m_o,
  output logic   ar_valid_m_o,
  input  logic   ar_ready_m_i,
  input  id_t    r_id_m_i,
  input  data_t  r_data_m_i,
  input  resp_t  r_resp_m_i,
  input  logic   r_valid_m_i,
  output logic   r_ready_m_o
);

  len_queue_if wr_q ();
  len_queue_if rd_q ();

  // Every downstream request is a single beat
  assign aw_len_m_o = '0;
  assign ar_len_m_o = '0;

  // W goes straight through, each beat ends its own one-beat burst
  assign w_data_m_o  = w_data_s_i;
  assign w_strb_m_o  = w_strb_s_i;
  assign w_last_m_o  = 1'b1;
  assign w_valid_m_o = w_valid_s_i;
  assign w_ready_s_o = w_ready_m_i;

  // ------------------------------
  // Write path
  // ------------------------------
  ax_splitter u_aw_split (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .id_i    (aw_id_s_i),
    .addr_i  (aw_addr_s_i),
    .len_i   (aw_len_s_i),
    .size_i  (aw_size_s_i),
    .burst_i (aw_burst_s_i),
    .valid_i (aw_valid_s_i),
    .ready_o (aw_ready_s_o),
    .id_o    (aw_id_m_o),
    .addr_o  (aw_addr_m_o),
    .size_o  (aw_size_m_o),
    .burst_o (aw_burst_m_o),
    .valid_o (aw_valid_m_o),
    .ready_i (aw_ready_m_i),
    .q       (wr_q.splitter)
  );

  burst_len_queue u_wr_queue (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .q       (wr_q.queue)
  );

  b_merger u_b_merge (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .b_id_i    (b_id_m_i),
    .b_resp_i  (b_resp_m_i),
    .b_valid_i (b_valid_m_i),
    .b_ready_o (b_ready_m_o),
    .b_id_o    (b_id_s_o),
    .b_resp_o  (b_resp_s_o),
    .b_valid_o (b_valid_s_o),
    .b_ready_i (b_ready_s_i),
    .q         (wr_q.consumer)
  );

  // ------------------------------
  // Read path
  // ------------------------------
  ax_splitter u_ar_split (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .id_i    (ar_id_s_i),
    .addr_i  (ar_addr_s_i),
    .len_i   (ar_len_s_i),
    .size_i  (ar_size_s_i),
    .burst_i (ar_burst_s_i),
    .valid_i (ar_valid_s_i),
    .ready_o (ar_ready_s_o),
    .id_o    (ar_id_m_o),
    .addr_o  (ar_addr_m_o),
    .size_o  (ar_size_m_o),
    .burst_o (ar_burst_m_o),
    .valid_o (ar_valid_m_o),
    .ready_i (ar_ready_m_i),
    .q       (rd_q.splitter)
  );

  burst_len_queue u_rd_queue (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .q       (rd_q.queue)
  );

  r_last_gen u_r_last (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .r_id_i    (r_id_m_i),
    .r_data_i  (r_data_m_i),
    .r_resp_i  (r_resp_m_i),
    .r_valid_i (r_valid_m_i),
    .r_ready_o (r_ready_m_o),
    .r_id_o    (r_id_s_o),
    .r_data_o  (r_data_s_o),
    .r_resp_o  (r_resp_s_o),
    .r_last_o  (r_last_s_o),
    .r_valid_o (r_valid_s_o),
    .r_ready_i (r_ready_s_i),
    .q         (rd_q.consumer)
  );

endmodule

/* dv/tb_axi_slave_model.sv */
`timescale 1ns/1ps

module tb_axi_slave_model import burst_split_pkg::*; #(
  parameter int SEED = 11
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  id_t   aw_id_i,
  input  addr_t aw_addr_i,
  input  logic  aw_valid_i,
  output logic  aw_ready_o,
  input  logic  w_valid_i,
  output logic  w_ready_o,
  output id_t   b_id_o,
  output resp_t b_resp_o,
  output logic  b_valid_o,
  input  logic  b_ready_i,
  input  id_t   ar_id_i,
  input  addr_t ar_addr_i,
  input  logic  ar_valid_i,
  output logic  ar_ready_o,
  output id_t   r_id_o,
  output data_t r_data_o,
  output resp_t r_resp_o,
  output logic  r_valid_o,
  input  logic  r_ready_i
);

  typedef struct packed {
    id_t   id;
    addr_t addr;
  } req_t;

  integer seed = SEED;
  req_t   aw_q[$];
  req_t   b_q[$];
  req_t   r_q[$];
  int     w_cnt;
  // Cycles each channel still stalls
  int     aw_wait, w_wait, ar_wait, b_wait, r_wait;

  function automatic int stall_cycles();
    return $unsigned($random(seed)) % 3;
  endfunction

  // Handshakes taken at the rising edge
  always @(posedge clk_i) begin
    if (reset_i) begin
      aw_q.delete();
      b_q.delete();
      r_q.delete();
      w_cnt   = 0;
      aw_wait = 0;
      w_wait  = 0;
      ar_wait = 0;
      b_wait  = 0;
      r_wait  = 0;
    end else begin
      if (aw_valid_i && aw_ready_o) begin
        aw_q.push_back({aw_id_i, aw_addr_i});
        aw_wait = stall_cycles();
      end else if (aw_wait > 0) begin
        aw_wait--;
      end
      if (w_valid_i && w_ready_o) begin
        w_cnt++;
        w_wait = stall_cycles();
      end else if (w_wait > 0) begin
        w_wait--;
      end
      if (ar_valid_i && ar_ready_o) begin
        r_q.push_back({ar_id_i, ar_addr_i});
        ar_wait = stall_cycles();
      end else if (ar_wait > 0) begin
        ar_wait--;
      end
      // A write completes once both its address and its data are in
      while (aw_q.size() != 0 && w_cnt != 0) begin
        b_q.push_back(aw_q.pop_front());
        w_cnt--;
      end
      if (b_valid_o && b_ready_i) begin
        b_q.delete(0);
        b_wait = stall_cycles();
      end else if (b_wait > 0) begin
        b_wait--;
      end
      if (r_valid_o && r_ready_i) begin
        r_q.delete(0);
        r_wait = stall_cycles();
      end else if (r_wait > 0) begin
        r_wait--;
      end
    end
  end

  // Outputs change on the falling edge only
  initial begin
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    ar_ready_o = 1'b0;
    b_valid_o  = 1'b0;
    b_id_o     = '0;
    b_resp_o   = RESP_OKAY;
    r_valid_o  = 1'b0;
    r_id_o     = '0;
    r_data_o   = '0;
    r_resp_o   = RESP_OKAY;
    forever begin
      @(negedge clk_i);
      aw_ready_o = !reset_i && (aw_wait == 0);
      w_ready_o  = !reset_i && (w_wait == 0);
      ar_ready_o = !reset_i && (ar_wait == 0);
      b_valid_o  = !reset_i && (b_q.size() != 0) && (b_wait == 0);
      r_valid_o  = !reset_i && (r_q.size() != 0) && (r_wait == 0);
      if (b_q.size() != 0) begin
        b_id_o   = b_q[0].id;
        b_resp_o = (b_q[0].addr[7:4] == 4'hE) ? RESP_SLVERR : RESP_OKAY;
      end
      if (r_q.size() != 0) begin
        r_id_o   = r_q[0].id;
        r_data_o = ~r_q[0].addr;
        r_resp_o = RESP_OKAY;
      end
    end
  end

endmodule

/* dv/tb_burst_splitter.sv */
`timescale 1ns/1ps

module tb_burst_splitter import burst_split_pkg::*; ();

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    size_t  size;
    burst_t burst;
  } ax_exp_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_exp_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_exp_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } r_exp_t;

  logic   clk_i;
  logic   reset_i;
  id_t    aw_id_s_i, ar_id_s_i, aw_id_m_o, ar_id_m_o;
  addr_t  aw_addr_s_i, ar_addr_s_i, aw_addr_m_o, ar_addr_m_o;
  len_t   aw_len_s_i, ar_len_s_i, aw_len_m_o, ar_len_m_o;
  size_t  aw_size_s_i, ar_size_s_i, aw_size_m_o, ar_size_m_o;
  burst_t aw_burst_s_i, ar_burst_s_i, aw_burst_m_o, ar_burst_m_o;
  logic   aw_valid_s_i, aw_ready_s_o, aw_valid_m_o, aw_ready_m_i;
  logic   ar_valid_s_i, ar_ready_s_o, ar_valid_m_o, ar_ready_m_i;
  data_t  w_data_s_i, w_data_m_o;
  strb_t  w_strb_s_i, w_strb_m_o;
  logic   w_valid_s_i, w_ready_s_o, w_last_m_o, w_valid_m_o, w_ready_m_i;
  id_t    b_id_s_o, b_id_m_i, r_id_s_o, r_id_m_i;
  resp_t  b_resp_s_o, b_resp_m_i, r_resp_s_o, r_resp_m_i;
  logic   b_valid_s_o, b_ready_s_i, b_valid_m_i, b_ready_m_o;
  data_t  r_data_s_o, r_data_m_i;
  logic   r_last_s_o, r_valid_s_o, r_ready_s_i, r_valid_m_i, r_ready_m_o;

  integer  seed = 11;
  int      errors;
  int      total_beats;
  int      b_seen;
  int      r_seen;
  logic    drop_ready;
  ax_exp_t exp_aw[$];
  ax_exp_t exp_ar[$];
  w_exp_t  exp_w[$];
  b_exp_t  exp_b[$];
  r_exp_t  exp_r[$];
  ax_exp_t aw_want;
  ax_exp_t ar_want;
  w_exp_t  w_want;
  b_exp_t  b_want;
  r_exp_t  r_want;

  burst_splitter uut (.*);

  tb_axi_slave_model slave (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .aw_id_i    (aw_id_m_o),
    .aw_addr_i  (aw_addr_m_o),
    .aw_valid_i (aw_valid_m_o),
    .aw_ready_o (aw_ready_m_i),
    .w_valid_i  (w_valid_m_o),
    .w_ready_o  (w_ready_m_i),
    .b_id_o     (b_id_m_i),
    .b_resp_o   (b_resp_m_i),
    .b_valid_o  (b_valid_m_i),
    .b_ready_i  (b_ready_m_o),
    .ar_id_i    (ar_id_m_o),
    .ar_addr_i  (ar_addr_m_o),
    .ar_valid_i (ar_valid_m_o),
    .ar_ready_o (ar_ready_m_i),
    .r_id_o     (r_id_m_i),
    .r_data_o   (r_data_m_i),
    .r_resp_o   (r_resp_m_i),
    .r_valid_o  (r_valid_m_i),
    .r_ready_i  (r_ready_m_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ------------------------------
  // Reference model and checks
  // ------------------------------
  // Expected beats of one burst, appended to the expect queues
  function automatic void model_burst(input logic is_write, input id_t id, input addr_t addr,
                                      input len_t len, input size_t size, input burst_t burst);
    addr_t   a;
    logic    err;
    ax_exp_t ax;
    r_exp_t  r;
    b_exp_t  b;
    a   = addr;
    err = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      ax.id    = id;
      ax.addr  = a;
      ax.size  = size;
      ax.burst = burst;
      if (is_write) begin
        exp_aw.push_back(ax);
        if (a[7:4] == 4'hE) begin
          err = 1'b1;
        end
      end else begin
        exp_ar.push_back(ax);
        r.id   = id;
        r.data = ~a;
        r.last = (i == int'(len));
        exp_r.push_back(r);
      end
      if (burst == BURST_INCR) begin
        a = a + (32'd1 << size);
      end
    end
    if (is_write) begin
      b.id   = id;
      b.resp = err ? RESP_SLVERR : RESP_OKAY;
      exp_b.push_back(b);
    end
    total_beats += int'(len) + 1;
  endfunction

  function automatic void check_value(input string name, input logic [31:0] got,
                                      input logic [31:0] want);
    assert (got === want) else begin
      errors++;
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, want);
    end
  endfunction

  function automatic bit beat_expected(input string chan, input int pending);
    assert (pending != 0) else begin
      errors++;
      $display("At %0t a %s beat arrived that was not expected", $time, chan);
    end
    return pending != 0;
  endfunction

  // Downstream requests and W beats
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (aw_valid_m_o && aw_ready_m_i && beat_expected("AW", exp_aw.size())) begin
        aw_want = exp_aw.pop_front();
        check_value("aw_id_m_o", aw_id_m_o, aw_want.id);
        check_value("aw_addr_m_o", aw_addr_m_o, aw_want.addr);
        check_value("aw_size_m_o", aw_size_m_o, aw_want.size);
        check_value("aw_burst_m_o", aw_burst_m_o, aw_want.burst);
        check_value("aw_len_m_o", aw_len_m_o, 32'd0);
      end
      if (ar_valid_m_o && ar_ready_m_i && beat_expected("AR", exp_ar.size())) begin
        ar_want = exp_ar.pop_front();
        check_value("ar_id_m_o", ar_id_m_o, ar_want.id);
        check_value("ar_addr_m_o", ar_addr_m_o, ar_want.addr);
        check_value("ar_size_m_o", ar_size_m_o, ar_want.size);
        check_value("ar_burst_m_o", ar_burst_m_o, ar_want.burst);
        check_value("ar_len_m_o", ar_len_m_o, 32'd0);
      end
      if (w_valid_m_o && w_ready_m_i && beat_expected("W", exp_w.size())) begin
        w_want = exp_w.pop_front();
        check_value("w_data_m_o", w_data_m_o, w_want.data);
        check_value("w_strb_m_o", w_strb_m_o, w_want.strb);
        check_value("w_last_m_o", w_last_m_o, 32'd1);
      end
    end
  end

  // Upstream responses in issue order
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (b_valid_s_o && b_ready_s_i && beat_expected("B", exp_b.size())) begin
        b_want = exp_b.pop_front();
        check_value("b_id_s_o", b_id_s_o, b_want.id);
        check_value("b_resp_s_o", b_resp_s_o, b_want.resp);
        b_seen++;
      end
      if (r_valid_s_o && r_ready_s_i && beat_expected("R", exp_r.size())) begin
        r_want = exp_r.pop_front();
        check_value("r_id_s_o", r_id_s_o, r_want.id);
        check_value("r_data_s_o", r_data_s_o, r_want.data);
        check_value("r_resp_s_o", r_resp_s_o, RESP_OKAY);
        check_value("r_last_s_o", r_last_s_o, r_want.last);
        r_seen++;
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  // Tasks start and end just after a falling edge
  task automatic send_aw(input id_t id, input addr_t addr, input len_t len, input size_t size,
                         input burst_t burst);
    aw_id_s_i    = id;
    aw_addr_s_i  = addr;
    aw_len_s_i   = len;
    aw_size_s_i  = size;
    aw_burst_s_i = burst;
    aw_valid_s_i = 1'b1;
    @(posedge clk_i);
    while (!aw_ready_s_o) @(posedge clk_i);
    @(negedge clk_i);
    aw_valid_s_i = 1'b0;
  endtask

  task automatic send_ar(input id_t id, input addr_t addr, input len_t len, input size_t size,
                         input burst_t burst);
    ar_id_s_i    = id;
    ar_addr_s_i  = addr;
    ar_len_s_i   = len;
    ar_size_s_i  = size;
    ar_burst_s_i = burst;
    ar_valid_s_i = 1'b1;
    @(posedge clk_i);
    while (!ar_ready_s_o) @(posedge clk_i);
    @(negedge clk_i);
    ar_valid_s_i = 1'b0;
  endtask

  task automatic send_w(input int beats);
    for (int i = 0; i < beats; i++) begin
      w_data_s_i  = $random(seed);
      w_strb_s_i  = strb_t'($random(seed));
      w_valid_s_i = 1'b1;
      // W passes through unchanged
      exp_w.push_back({w_data_s_i, w_strb_s_i});
      @(posedge clk_i);
      while (!w_ready_s_o) @(posedge clk_i);
      @(negedge clk_i);
    end
    w_valid_s_i = 1'b0;
  endtask

  task automatic write_burst(input id_t id, input addr_t addr, input len_t len, input size_t size,
                             input burst_t burst);
    model_burst(1'b1, id, addr, len, size, burst);
    fork
      send_aw(id, addr, len, size, burst);
      send_w(int'(len) + 1);
    join
  endtask

  task automatic read_burst(input id_t id, input addr_t addr, input len_t len, input size_t size,
                            input burst_t burst);
    model_burst(1'b0, id, addr, len, size, burst);
    send_ar(id, addr, len, size, burst);
  endtask

  task automatic random_burst(input logic is_write, input burst_t burst, input int max_len);
    id_t   id;
    addr_t addr;
    len_t  len;
    size_t size;
    id   = id_t'($random(seed));
    size = size_t'($unsigned($random(seed)) % 3);
    len  = len_t'($unsigned($random(seed)) % max_len);
    addr = $random(seed);
    addr = addr & ~((32'd1 << size) - 1);
    if (is_write) begin
      write_burst(id, addr, len, size, burst);
    end else begin
      read_burst(id, addr, len, size, burst);
    end
  endtask

  // Upstream response ready, dropped at random when enabled
  initial begin
    b_ready_s_i = 1'b0;
    r_ready_s_i = 1'b0;
    forever begin
      @(negedge clk_i);
      b_ready_s_i = !reset_i && (!drop_ready || (($random(seed) & 3) != 0));
      r_ready_s_i = !reset_i && (!drop_ready || (($random(seed) & 3) != 0));
    end
  end

  initial begin
    reset_i      = 1'b1;
    drop_ready   = 1'b0;
    aw_id_s_i    = '0;
    aw_addr_s_i  = '0;
    aw_len_s_i   = '0;
    aw_size_s_i  = '0;
    aw_burst_s_i = BURST_INCR;
    aw_valid_s_i = 1'b0;
    ar_id_s_i    = '0;
    ar_addr_s_i  = '0;
    ar_len_s_i   = '0;
    ar_size_s_i  = '0;
    ar_burst_s_i = BURST_INCR;
    ar_valid_s_i = 1'b0;
    w_data_s_i   = '0;
    w_strb_s_i   = '0;
    w_valid_s_i  = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    repeat (4) random_burst(1'b1, BURST_INCR, 16);
    repeat (3) random_burst(1'b0, BURST_FIXED, 16);
    // One burst crosses the error window, the next stays clean
    write_burst(4'h3, 32'h1000_00D8, 8'd5, 3'd2, BURST_INCR);
    write_burst(4'h4, 32'h1000_0100, 8'd3, 3'd2, BURST_INCR);
    write_burst(4'h5, 32'h2000_0040, 8'd0, 3'd2, BURST_INCR);
    read_burst(4'h6, 32'h2000_0044, 8'd0, 3'd2, BURST_INCR);

    drop_ready = 1'b1;
    repeat (6) begin
      random_burst(1'b1, BURST_INCR, 8);
      random_burst(1'b0, BURST_INCR, 8);
      random_burst(1'b0, BURST_FIXED, 8);
    end
    // Enough reads to fill the length queue
    repeat (MAX_TXNS + 3) random_burst(1'b0, BURST_INCR, 4);

    while (exp_b.size() != 0 || exp_r.size() != 0) @(posedge clk_i);
    repeat (10) @(posedge clk_i);
    assert (exp_aw.size() == 0 && exp_ar.size() == 0 && exp_w.size() == 0) else begin
      errors++;
      $display("Some downstream requests never appeared");
    end
    $display("Errors: %0d, B checked: %0d, R checked: %0d", errors, b_seen, r_seen);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Limit grows with the beats issued so far
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < total_beats * 10 + 1000) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("The run hung, timeout after %0d cycles", cycles);
    $display("Errors: %0d, B checked: %0d, R checked: %0d", errors, b_seen, r_seen);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* src.f */
rtl/burst_split_pkg.sv
rtl/len_queue_if.sv
rtl/ax_splitter.sv
rtl/burst_len_queue.sv
rtl/b_merger.sv
rtl/r_last_gen.sv
rtl/burst_splitter.sv
dv/tb_axi_slave_model.sv
dv/tb_burst_splitter.sv

/* Bender.yml */
package:
  name: burst_splitter

sources:
  - files:
      - rtl/burst_split_pkg.sv
      - rtl/len_queue_if.sv
      - rtl/ax_splitter.sv
      - rtl/burst_len_queue.sv
      - rtl/b_merger.sv
      - rtl/r_last_gen.sv
      - rtl/burst_splitter.sv
  - target: test
    files:
      - dv/tb_axi_slave_model.sv
      - dv/tb_burst_splitter.sv
